// ==== Bender.yml ====
package:
  name: cache_top

sources:
  - logic/cache_pkg.sv
  - logic/mru_store.sv
  - logic/replacement_policy.sv
  - logic/tag_store.sv
  - logic/data_store.sv
  - logic/cache_ctrl.sv
  - logic/cache_top.sv
  - target: simulation
    files:
      - dv/backend_mem.sv
      - dv/cache_tb.sv

// ==== cache_top.f ====
logic/cache_pkg.sv
logic/mru_store.sv
logic/replacement_policy.sv
logic/tag_store.sv
logic/data_store.sv
logic/cache_ctrl.sv
logic/cache_top.sv
dv/backend_mem.sv
dv/cache_tb.sv

// ==== dv/backend_mem.sv ====
`timescale 1ns/1ps

module backend_mem #(
   parameter int max_lat = 6   // longest ack latency in cycles
) (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                mem_req,
   input  cache_pkg::mem_req_t mem_out,
   output logic                mem_ack,
   output cache_pkg::word_t    mem_rdata
);

   import cache_pkg::*;

   word_t       mem [addr_t];   // only written words are stored
   mem_req_t    req_q;
   logic        pending;        // one request in flight
   int unsigned wait_cnt;

   // every address bit shows up in the word
   function automatic word_t fill_word(input addr_t a);
      return {a ^ 16'hc3a5, ~a};
   endfunction

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pending   <= 1'b0;
         mem_ack   <= 1'b0;
         mem_rdata <= '0;
         wait_cnt  <= 0;
      end else begin
         mem_ack <= 1'b0;   // pulse
         if (mem_req) begin
            pending  <= 1'b1;
            req_q    <= mem_out;
            wait_cnt <= $urandom_range(max_lat, 1) - 1;   // random latency per request
         end else if (pending) begin
            if (wait_cnt == 0) begin
               pending <= 1'b0;
               mem_ack <= 1'b1;
               if (req_q.we) begin
                  mem[req_q.addr] = req_q.wdata;   // store the written word
               end else begin
                  mem_rdata <= mem.exists(req_q.addr) ? mem[req_q.addr] : fill_word(req_q.addr);
               end
            end else begin
               wait_cnt <= wait_cnt - 1;
            end
         end
      end
   end

endmodule

// ==== dv/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;

   import cache_pkg::*;

   localparam int n_ways = 4;
   localparam int set_w  = 3;
   localparam int way_w  = $clog2(n_ways);
   localparam int addr_w = $bits(addr_t);
   localparam int tag_w  = addr_w - set_w;
   localparam int n_sets = 2**set_w;
   localparam int half_period = 2;   // 4 ns clock
   localparam int n_rand = 300;
   localparam int n_reqs = 60 + n_rand;   // directed part stays below 60

   logic clk, arst_n, cpu_req, busy, cpu_done, mem_req, mem_ack;
   cpu_req_t cpu_in;
   mem_req_t mem_out, last_mem;
   word_t    cpu_rdata, mem_rdata;

   // reference model
   word_t            ref_mem [addr_t];
   logic             shadow_valid [n_sets][n_ways];
   logic [tag_w-1:0] shadow_tag [n_sets][n_ways];
   logic [n_ways-1:1] tree [n_sets];   // heap order where 1 means the right half is older

   string test_name;
   int    mem_cnt, mem_delta, last_lat;
   logic  mem_pending;

   cache_top #(.n_ways(n_ways), .set_w(set_w), .policy(plru_tree)) UUT (
      .clk, .arst_n, .cpu_req, .cpu_in, .busy, .cpu_done, .cpu_rdata,
      .mem_req, .mem_out, .mem_ack, .mem_rdata
   );

   backend_mem #(.max_lat(6)) u_mem (
      .clk, .arst_n, .mem_req, .mem_out, .mem_ack, .mem_rdata
   );

   always #half_period clk = ~clk;

   task automatic fail_value(input string what, input logic [63:0] exp, input logic [63:0] act);
      $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, exp, act);
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic fail_plain(input string msg);
      $display("%s during %s", msg, test_name);
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   function automatic word_t fill_word(input addr_t a);
      return {a ^ 16'hc3a5, ~a};   // same pattern the memory starts with
   endfunction

   function automatic word_t ref_word(input addr_t a);
      return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
   endfunction

   function automatic addr_t make_addr(input int t, input int s);
      return addr_t'((t << set_w) | s);
   endfunction

   function automatic int find_way(input addr_t a);
      int s;
      s = int'(a[set_w-1:0]);
      for (int w = 0; w < n_ways; w++) begin
         if (shadow_valid[s][w] && shadow_tag[s][w] == a[addr_w-1:set_w]) return w;
      end
      return -1;   // miss
   endfunction

   // walk from the root along the direction bits
   function automatic int tree_victim(input int s);
      int node;
      node = 1;
      for (int l = 0; l < way_w; l++) begin
         node = 2 * node + int'(tree[s][node]);
      end
      return node - n_ways;
   endfunction

   function automatic void tree_touch(input int s, input int w);
      int node;
      int b;
      node = 1;
      for (int l = way_w - 1; l >= 0; l--) begin
         b = (w >> l) & 1;
         tree[s][node] = (b == 0);   // point at the other half
         node = 2 * node + b;
      end
   endfunction

   // one request that returns at the negedge where cpu_done is seen
   task automatic send_request(input logic we, input addr_t a, input word_t d);
      int mem_before;
      @(negedge clk);
      while (busy) @(negedge clk);
      mem_before = mem_cnt;
      @(posedge clk);
      cpu_req <= 1'b1;
      cpu_in  <= '{we: we, addr: a, wdata: d};
      @(posedge clk);
      cpu_req  <= 1'b0;
      last_lat = 1;
      @(negedge clk);
      while (!cpu_done) begin
         @(posedge clk);
         last_lat++;
         @(negedge clk);
      end
      mem_delta = mem_cnt - mem_before;
   endtask

   task automatic check_read(input addr_t a);
      int    s, hw, vw;
      word_t exp;
      s   = int'(a[set_w-1:0]);
      hw  = find_way(a);
      exp = ref_word(a);
      send_request(1'b0, a, '0);
      assert (cpu_rdata == exp) else fail_value("read data", exp, cpu_rdata);
      if (hw >= 0) begin
         assert (mem_delta == 0) else fail_value("mem_req count on hit", 0, mem_delta);
         assert (last_lat == 2) else fail_value("hit latency", 2, last_lat);
         tree_touch(s, hw);
      end else begin
         assert (mem_delta == 1) else fail_value("mem_req count on miss", 1, mem_delta);
         vw = tree_victim(s);   // refill lands in the predicted way
         shadow_valid[s][vw] = 1'b1;
         shadow_tag[s][vw]   = a[addr_w-1:set_w];
         tree_touch(s, vw);
      end
   endtask

   // write-through with no allocate and no recency change
   task automatic check_write(input addr_t a, input word_t d);
      send_request(1'b1, a, d);
      ref_mem[a] = d;
      assert (mem_delta == 1) else fail_value("mem_req count on write", 1, mem_delta);
      assert (last_mem == {1'b1, a, d}) else fail_value("write-through", {1'b1, a, d}, last_mem);
   endtask

   // memory port monitor
   always @(negedge clk) begin
      if (arst_n) begin
         assert (!(cpu_req && busy)) else fail_plain("request driven while the cache was busy");
         if (mem_ack) mem_pending = 1'b0;
         if (mem_req) begin
            assert (!mem_pending) else fail_plain("second memory request before the ack");
            mem_pending = 1'b1;
            mem_cnt++;
            last_mem = mem_out;
         end
      end
   end

   initial begin : watchdog
      repeat (n_reqs * 20 + 10) @(posedge clk);
      $display("timeout, the cache stopped answering during %s", test_name);
      $display("ERRORS FOUND");
      $fatal(1);
   end

   initial begin
      addr_t old;
      int    vw;
      void'($urandom(32'h34f44644));
      clk         = 1'b0;
      arst_n      = 1'b0;
      cpu_req     = 1'b0;
      cpu_in      = '0;
      mem_cnt     = 0;
      mem_pending = 1'b0;
      test_name   = "reset";
      for (int s = 0; s < n_sets; s++) begin
         tree[s] = '0;
         for (int w = 0; w < n_ways; w++) shadow_valid[s][w] = 1'b0;
      end
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      assert (!busy && !cpu_done && !mem_req) else fail_plain("outputs not idle after reset");

      test_name = "read_hit";   // first read misses and the second hits in two cycles
      for (int i = 0; i < 6; i++) begin
         check_read(make_addr(i + 1, i % 3));
         check_read(make_addr(i + 1, i % 3));
      end

      test_name = "write_read";   // write hit followed by write miss
      for (int i = 0; i < 4; i++) begin
         check_read(make_addr(40 + i, 3));
         check_write(make_addr(40 + i, 3), $urandom);
         check_read(make_addr(40 + i, 3));
         check_write(make_addr(50 + i, 4), $urandom);
         check_read(make_addr(50 + i, 4));
      end

      test_name = "replacement";
      for (int t = 16; t < 20; t++) check_read(make_addr(t, 5));
      check_read(make_addr(16, 5));
      check_read(make_addr(18, 5));
      vw  = tree_victim(5);
      old = make_addr(int'(shadow_tag[5][vw]), 5);
      check_read(make_addr(20, 5));   // evicts the predicted way
      for (int t = 16; t < 20; t++) begin
         if (make_addr(t, 5) != old) check_read(make_addr(t, 5));
      end
      check_read(old);   // must go to memory again

      test_name = "random";
      for (int i = 0; i < n_rand; i++) begin
         if ($urandom_range(2, 0) == 0) check_write(addr_t'($urandom_range(63, 0)), $urandom);
         else check_read(addr_t'($urandom_range(63, 0)));
      end

      $display("NO ERRORS");
      $finish;
   end

endmodule

// ==== logic/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl #(
   parameter int n_ways = cache_pkg::n_ways_dflt,
   parameter int set_w  = cache_pkg::set_w_dflt
) (
   input  logic                                      clk,
   input  logic                                      arst_n,
   // requester
   input  logic                                      cpu_req,
   input  cache_pkg::cpu_req_t                       cpu_in,
   output logic                                      busy,
   output logic                                      cpu_done,
   output cache_pkg::word_t                          cpu_rdata,
   // memory
   output logic                                      mem_req,
   output cache_pkg::mem_req_t                       mem_out,
   input  logic                                      mem_ack,
   input  cache_pkg::word_t                          mem_rdata,
   // stores and policy
   input  logic [n_ways-1:0]                         hit_way,
   input  logic [n_ways-1:0]                         victim_way,
   input  cache_pkg::word_t                          rd_data,
   output logic [set_w-1:0]                          set_idx,
   output logic [$bits(cache_pkg::addr_t)-set_w-1:0] tag,
   output logic                                      upd_en,
   output logic [n_ways-1:0]                         upd_way,
   output logic                                      fill_en,
   output logic [n_ways-1:0]                         fill_way,
   output logic                                      wr_en,
   output logic [n_ways-1:0]                         wr_way,
   output cache_pkg::word_t                          wr_data,
   output logic [$clog2(n_ways)-1:0]                 rd_way
);

   import cache_pkg::*;

   localparam int way_w = $clog2(n_ways);

   ctrl_state_e state;
   cpu_req_t    req_q;     // request held for the whole transaction
   logic        hit;

   assign hit     = |hit_way;
   assign set_idx = req_q.addr[set_w-1:0];
   assign tag     = req_q.addr[$bits(addr_t)-1:set_w];
   assign rd_way  = way_w'(onehot_to_bin(32'(hit_way)));
   assign mem_out = '{we: req_q.we, addr: req_q.addr, wdata: req_q.wdata};

   assign busy     = (state != idle);
   assign cpu_done = (state == done);   // one-cycle pulse from the registered state

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= idle;
         mem_req <= 1'b0;
      end else begin
         mem_req <= 1'b0;   // pulse
         case (state)
            idle: if (cpu_req) state <= lookup;
            lookup: begin
               if (!req_q.we && hit) begin
                  state <= done;
               end else begin
                  state   <= req_q.we ? wr_mem : refill;   // write always goes out
                  mem_req <= 1'b1;
               end
            end
            refill: if (mem_ack) state <= fill;   // wait as long as memory needs
            fill:   state <= done;
            wr_mem: if (mem_ack) state <= done;
            done:   state <= idle;
            default: state <= idle;
         endcase
      end
   end

   // request and read data capture
   always_ff @(posedge clk) begin
      if (state == idle && cpu_req) req_q <= cpu_in;
      if (state == lookup && hit) begin
         cpu_rdata <= rd_data;           // hit data
      end else if (state == refill && mem_ack) begin
         cpu_rdata <= mem_rdata;         // also the fill word
      end
   end

   // store strobes
   always_comb begin
      upd_en   = 1'b0;
      upd_way  = '0;
      fill_en  = 1'b0;
      fill_way = '0;
      wr_en    = 1'b0;
      wr_way   = '0;
      wr_data  = req_q.wdata;
      if (state == lookup && hit) begin
         if (req_q.we) begin
            wr_en  = 1'b1;               // write hit updates data only
            wr_way = hit_way;
         end else begin
            upd_en  = 1'b1;              // read hit refreshes recency
            upd_way = hit_way;
         end
      end else if (state == fill) begin
         upd_en   = 1'b1;
         upd_way  = victim_way;
         fill_en  = 1'b1;                // tag and valid
         fill_way = victim_way;
         wr_en    = 1'b1;
         wr_way   = victim_way;
         wr_data  = cpu_rdata;           // word captured on the ack
      end
   end

endmodule

// ==== logic/cache_pkg.sv ====
package cache_pkg;

   localparam int addr_w = 16;      // word address width
   localparam int word_w = 32;      // one data word per line

   // defaults, overridden from the top level
   localparam int n_ways_dflt = 4;
   localparam int set_w_dflt  = 3;  // 8 sets

   typedef logic [addr_w-1:0] addr_t;
   typedef logic [word_w-1:0] word_t;

   typedef enum logic [1:0] {
      lru,                          // true lru with per-way ages
      plru_mru,                     // one recency bit per way
      plru_tree                     // binary tree of direction bits
   } rep_policy_e;

   typedef enum logic [2:0] {
      idle, lookup, refill, fill, wr_mem, done
   } ctrl_state_e;

   typedef struct packed {
      logic  we;                    // 1 = write
      addr_t addr;
      word_t wdata;
   } cpu_req_t;

   typedef struct packed {
      logic  we;
      addr_t addr;
      word_t wdata;                 // write-through data
   } mem_req_t;

   // or of the indices of all set bits, exact for a one-hot input
   function automatic int unsigned onehot_to_bin(input logic [31:0] onehot);
      int unsigned bin;
      bin = 0;
      for (int i = 0; i < 32; i++) begin
         if (onehot[i]) bin = bin | i;
      end
      return bin;
   endfunction

endpackage

// ==== logic/cache_top.sv ====
`timescale 1ns/1ps

module cache_top #(
   parameter int                     n_ways = cache_pkg::n_ways_dflt,
   parameter int                     set_w  = cache_pkg::set_w_dflt,
   parameter cache_pkg::rep_policy_e policy = cache_pkg::plru_tree
) (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                cpu_req,
   input  cache_pkg::cpu_req_t cpu_in,
   output logic                busy,
   output logic                cpu_done,
   output cache_pkg::word_t    cpu_rdata,
   output logic                mem_req,
   output cache_pkg::mem_req_t mem_out,
   input  logic                mem_ack,
   input  cache_pkg::word_t    mem_rdata
);

   import cache_pkg::*;

   localparam int way_w = $clog2(n_ways);
   localparam int tag_w = $bits(addr_t) - set_w;

   logic [set_w-1:0]  set_idx;
   logic [tag_w-1:0]  tag;
   logic [n_ways-1:0] hit_way, victim_way;
   logic              upd_en, fill_en, wr_en;
   logic [n_ways-1:0] upd_way, fill_way, wr_way;
   logic [way_w-1:0]  rd_way;
   word_t             rd_data, wr_data;

   cache_ctrl #(.n_ways(n_ways), .set_w(set_w)) u_ctrl (
      .clk, .arst_n, .cpu_req, .cpu_in, .busy, .cpu_done, .cpu_rdata,
      .mem_req, .mem_out, .mem_ack, .mem_rdata,
      .hit_way, .victim_way, .rd_data, .set_idx, .tag,
      .upd_en, .upd_way, .fill_en, .fill_way,
      .wr_en, .wr_way, .wr_data, .rd_way
   );

   tag_store #(.n_ways(n_ways), .set_w(set_w)) u_tags (
      .clk, .arst_n, .set_idx, .tag, .fill_en, .fill_way, .hit_way
   );

   data_store #(.n_ways(n_ways), .set_w(set_w)) u_data (
      .clk, .set_idx, .wr_en, .wr_way,
      .wdata (wr_data),
      .rd_way,
      .rdata (rd_data)
   );

   replacement_policy #(.n_ways(n_ways), .set_w(set_w), .policy(policy)) u_policy (
      .clk, .arst_n, .upd_en, .upd_way, .set_idx, .victim_way,
      .victim_bin ()   // controller works on the one-hot form
   );

endmodule

// ==== logic/data_store.sv ====
`timescale 1ns/1ps

module data_store #(
   parameter int n_ways = cache_pkg::n_ways_dflt,
   parameter int set_w  = cache_pkg::set_w_dflt
) (
   input  logic                      clk,
   input  logic [set_w-1:0]          set_idx,
   input  logic                      wr_en,
   input  logic [n_ways-1:0]         wr_way,   // one-hot write way
   input  cache_pkg::word_t          wdata,
   input  logic [$clog2(n_ways)-1:0] rd_way,   // binary way number
   output cache_pkg::word_t          rdata
);

   import cache_pkg::*;

   word_t mem [2**set_w][n_ways];   // one word per set and way

   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int w = 0; w < n_ways; w++) begin
            if (wr_way[w]) mem[set_idx][w] <= wdata;
         end
      end
   end

   assign rdata = mem[set_idx][rd_way];   // hit way read out

endmodule

// ==== logic/mru_store.sv ====
`timescale 1ns/1ps

module mru_store #(
   parameter int data_w = 4,
   parameter int set_w  = 3
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              we,
   input  logic [set_w-1:0]  addr,
   input  logic [data_w-1:0] wdata,
   output logic [data_w-1:0] rdata
);

   logic [data_w-1:0] mem [2**set_w];   // one recency word per set

   // cleared so every set starts with no history
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 2**set_w; i++) begin
            mem[i] <= '0;
         end
      end else if (we) begin
         mem[addr] <= wdata;
      end
   end

   assign rdata = mem[addr];   // async read

endmodule

// ==== logic/replacement_policy.sv ====
`timescale 1ns/1ps

module replacement_policy #(
   parameter int                     n_ways = cache_pkg::n_ways_dflt,
   parameter int                     set_w  = cache_pkg::set_w_dflt,
   parameter cache_pkg::rep_policy_e policy = cache_pkg::plru_tree
) (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      upd_en,       // way just used, store new state
   input  logic [n_ways-1:0]         upd_way,
   input  logic [set_w-1:0]          set_idx,
   output logic [n_ways-1:0]         victim_way,   // one-hot
   output logic [$clog2(n_ways)-1:0] victim_bin
);

   import cache_pkg::*;

   localparam int way_w = $clog2(n_ways);

   typedef logic [way_w-1:0]  way_bin_t;
   typedef logic [n_ways-1:0] way_vec_t;

   generate
      if (policy == lru) begin : g_lru
         logic [n_ways*way_w-1:0] age_q;   // packed ages, way 0 in the low bits
         logic [n_ways*way_w-1:0] age_d;
         way_bin_t                age [n_ways];
         way_bin_t                used_age;

         always_comb begin
            // all-zero word means untouched set, so ages start as way index
            for (int i = 0; i < n_ways; i++) begin
               age[i] = (|age_q) ? age_q[i*way_w +: way_w] : way_bin_t'(i);
            end
            used_age = age[way_bin_t'(onehot_to_bin(32'(upd_way)))];
            for (int i = 0; i < n_ways; i++) begin
               if (upd_way[i]) begin
                  age_d[i*way_w +: way_w] = '1;                // newest
               end else if (age[i] > used_age) begin
                  age_d[i*way_w +: way_w] = age[i] - 1'b1;     // shift down
               end else begin
                  age_d[i*way_w +: way_w] = age[i];
               end
               victim_way[i] = (age[i] == '0);               // oldest way
            end
            victim_bin = way_bin_t'(onehot_to_bin(32'(victim_way)));
         end

         mru_store #(
            .data_w (n_ways*way_w),
            .set_w  (set_w)
         ) u_mru_store (
            .clk    (clk),
            .arst_n (arst_n),
            .we     (upd_en),
            .addr   (set_idx),
            .wdata  (age_d),
            .rdata  (age_q)
         );
      end else if (policy == plru_mru) begin : g_mru
         way_vec_t bits_q;   // 1 = used since last wrap
         way_vec_t bits_d;

         // when the last clear bit would be set, start over with the used way only
         assign bits_d = &(bits_q | upd_way) ? upd_way : (bits_q | upd_way);

         assign victim_way = ~bits_q & (bits_q + 1'b1);   // lowest clear bit
         assign victim_bin = way_bin_t'(onehot_to_bin(32'(victim_way)));

         mru_store #(
            .data_w (n_ways),
            .set_w  (set_w)
         ) u_mru_store (
            .clk    (clk),
            .arst_n (arst_n),
            .we     (upd_en),
            .addr   (set_idx),
            .wdata  (bits_d),
            .rdata  (bits_q)
         );
      end else begin : g_tree
         // heap numbering, root is node 1, leaves n_ways..2*n_ways-1 map to ways
         logic [n_ways-1:1] tree_q;   // 0 = go left, 1 = go right
         logic [n_ways-1:1] tree_d;

         always_comb begin : walk
            int       node;
            way_bin_t used;
            node = 1;
            for (int l = 0; l < way_w; l++) begin
               node = 2 * node + (tree_q[node] ? 1 : 0);   // follow the pointers
            end
            victim_bin = way_bin_t'(node - n_ways);
            victim_way = way_vec_t'(1) << victim_bin;

            // each node on the used path points to the other half
            tree_d = tree_q;
            used   = way_bin_t'(onehot_to_bin(32'(upd_way)));
            node   = 1;
            for (int l = 0; l < way_w; l++) begin
               tree_d[node] = ~used[way_w-1-l];
               node         = 2 * node + (used[way_w-1-l] ? 1 : 0);
            end
         end

         mru_store #(
            .data_w (n_ways-1),
            .set_w  (set_w)
         ) u_mru_store (
            .clk    (clk),
            .arst_n (arst_n),
            .we     (upd_en),
            .addr   (set_idx),
            .wdata  (tree_d),
            .rdata  (tree_q)
         );
      end
   endgenerate

endmodule

// ==== logic/tag_store.sv ====
`timescale 1ns/1ps

module tag_store #(
   parameter int n_ways = cache_pkg::n_ways_dflt,
   parameter int set_w  = cache_pkg::set_w_dflt
) (
   input  logic                                     clk,
   input  logic                                     arst_n,
   input  logic [set_w-1:0]                         set_idx,
   input  logic [$bits(cache_pkg::addr_t)-set_w-1:0] tag,
   input  logic                                     fill_en,
   input  logic [n_ways-1:0]                        fill_way,   // one-hot
   output logic [n_ways-1:0]                        hit_way     // one-hot, or zero on a miss
);

   import cache_pkg::*;

   localparam int tag_w = $bits(addr_t) - set_w;   // upper address bits

   typedef logic [tag_w-1:0] tag_t;

   logic [n_ways-1:0] valid [2**set_w];
   tag_t              tags  [2**set_w][n_ways];

   // valid bits start cleared, only a fill sets one
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int s = 0; s < 2**set_w; s++) begin
            valid[s] <= '0;
         end
      end else if (fill_en) begin
         valid[set_idx] <= valid[set_idx] | fill_way;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_en) begin
         for (int w = 0; w < n_ways; w++) begin
            if (fill_way[w]) tags[set_idx][w] <= tag;   // victim way gets the new tag
         end
      end
   end

   // parallel compare over all ways of the set
   always_comb begin
      for (int w = 0; w < n_ways; w++) begin
         hit_way[w] = valid[set_idx][w] && (tags[set_idx][w] == tag);
      end
   end

endmodule
